/* hdl/xaui_pkg.sv */
`default_nettype none

package xaui_pkg;

  localparam int n_lanes = 4;
  localparam int n_bytes = 2 * n_lanes;  // two bytes per lane each cycle

  // 8b/10b control characters as seen after decoding
  localparam logic [7:0] k28_5 = 8'hbc;  // comma /K/
  localparam logic [7:0] k28_3 = 8'h7c;  // align /A/
  localparam logic [7:0] k28_0 = 8'h1c;  // skip /R/
  localparam logic [7:0] k28_4 = 8'h9c;  // sequence /Q/
  localparam logic [7:0] k27_7 = 8'hfb;  // start /S/
  localparam logic [7:0] k29_7 = 8'hfd;  // terminate /T/
  localparam logic [7:0] k30_7 = 8'hfe;  // error /E/

  // one lane for one cycle
  typedef struct packed {
    logic [1:0][7:0] data;     // byte 0 is the earlier byte
    logic [1:0]      charisk;  // one k flag per byte
  } lane_word_t;

  // whole bank, lane 0 in the low bits
  typedef lane_word_t [n_lanes-1:0] lane_bus_t;

  // output of the comma alignment stage
  typedef struct packed {
    lane_bus_t          lanes;
    logic [n_lanes-1:0] lock;  // per lane, travels with the word
  } align_word_t;

  // user receive word, lane n at bits 16n+15:16n
  typedef struct packed {
    logic [n_bytes-1:0][7:0] data;
    logic [n_bytes-1:0]      charisk;
  } rx_word_t;

  typedef struct packed {
    logic [n_bytes-1:0] code_comma;
    logic [n_bytes-1:0] codevalid;
    logic [n_lanes-1:0] rxlock;
    logic [n_lanes-1:0] syncok;
  } rx_status_t;

  // user transmit word, same byte mapping as rx_word_t
  typedef struct packed {
    logic [n_bytes-1:0][7:0] data;
    logic [n_bytes-1:0]      charisk;
  } tx_word_t;

endpackage

`default_nettype wire

/* hdl/xaui_lane_fixup.sv */
`default_nettype none

module xaui_lane_fixup #(
  parameter logic [xaui_pkg::n_lanes-1:0] tx_polarity = '0,
  parameter logic [xaui_pkg::n_lanes-1:0] rx_polarity = '0,
  parameter bit                           rx_reverse  = 1'b0
) (
  input  logic                mgt_clk,
  input  logic                arst_n,
  input  xaui_pkg::tx_word_t  tx,
  input  xaui_pkg::lane_bus_t rx_lanes,
  input  logic                loopback,
  output xaui_pkg::lane_bus_t tx_lanes,
  output xaui_pkg::lane_bus_t fix_bus
);

  import xaui_pkg::*;

  lane_bus_t tx_split;   // logical tx lanes
  lane_bus_t tx_pins;    // tx lanes with board polarity applied
  lane_bus_t tx_log_q;   // registered logical lanes, feeds loopback
  lane_bus_t rx_fixed;   // external lanes with polarity undone
  lane_bus_t rx_order;   // external lanes in logical order
  lane_bus_t fix_d;

  // flips the data bits of the lanes selected by mask, k flags untouched
  function automatic lane_bus_t flip_data(input lane_bus_t bus,
                                          input logic [n_lanes-1:0] mask);
    lane_bus_t res;
    res = bus;
    for (int i = 0; i < n_lanes; i++) begin
      if (mask[i]) begin
        res[i].data = ~bus[i].data;
      end
    end
    return res;
  endfunction

  // split the 64-bit user word into lanes
  always_comb begin
    for (int i = 0; i < n_lanes; i++) begin
      tx_split[i].data[0]    = tx.data[2*i];
      tx_split[i].data[1]    = tx.data[2*i+1];
      tx_split[i].charisk[0] = tx.charisk[2*i];
      tx_split[i].charisk[1] = tx.charisk[2*i+1];
    end
  end

  assign tx_pins  = flip_data(tx_split, tx_polarity);
  assign rx_fixed = flip_data(rx_lanes, rx_polarity);

  // crossed rx pairs on the board, undo the lane order
  always_comb begin
    for (int i = 0; i < n_lanes; i++) begin
      if (rx_reverse) begin
        rx_order[n_lanes-1-i] = rx_fixed[i];
      end else begin
        rx_order[i] = rx_fixed[i];
      end
    end
  end

  // loopback sees the logical words, no board fixes apply
  assign fix_d = loopback ? tx_log_q : rx_order;

  always_ff @(posedge mgt_clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_log_q <= '0;
      tx_lanes <= '0;  // pins idle low out of reset
      fix_bus  <= '0;
    end else begin
      tx_log_q <= tx_split;
      tx_lanes <= tx_pins;
      fix_bus  <= fix_d;
    end
  end

endmodule

`default_nettype wire

/* hdl/rx_comma_align.sv */
`default_nettype none

module rx_comma_align (
  input  logic                   mgt_clk,
  input  logic                   arst_n,
  input  xaui_pkg::lane_bus_t    fix_bus,
  input  logic [xaui_pkg::n_lanes-1:0] enable_align,
  output xaui_pkg::align_word_t  align_bus
);

  import xaui_pkg::*;

  logic [n_lanes-1:0]      comma0;       // comma in byte 0
  logic [n_lanes-1:0]      comma1;       // comma in byte 1
  logic [n_lanes-1:0]      shift_q;      // lane is offset by one byte
  logic [n_lanes-1:0]      shift_d;
  logic [n_lanes-1:0]      lock_d;
  logic [n_lanes-1:0][7:0] prev_data_q;  // last cycle's byte 1
  logic [n_lanes-1:0]      prev_k_q;
  align_word_t             align_d;

  always_comb begin
    align_d = '0;
    for (int l = 0; l < n_lanes; l++) begin
      comma0[l] = fix_bus[l].charisk[0] && (fix_bus[l].data[0] == k28_5);
      comma1[l] = fix_bus[l].charisk[1] && (fix_bus[l].data[1] == k28_5);

      // byte 0 wins when both bytes carry a comma
      shift_d[l] = shift_q[l];
      if (enable_align[l]) begin
        if (comma0[l]) begin
          shift_d[l] = 1'b0;
        end else if (comma1[l]) begin
          shift_d[l] = 1'b1;
        end
      end

      // new shift decision already applies to this word
      align_d.lanes[l] = fix_bus[l];
      if (shift_d[l]) begin
        align_d.lanes[l].data[0]    = prev_data_q[l];
        align_d.lanes[l].charisk[0] = prev_k_q[l];
        align_d.lanes[l].data[1]    = fix_bus[l].data[0];
        align_d.lanes[l].charisk[1] = fix_bus[l].charisk[0];
      end

      lock_d[l] = enable_align[l] && (align_bus.lock[l] || comma0[l] || comma1[l]);
    end
    align_d.lock = lock_d;
  end

  always_ff @(posedge mgt_clk or negedge arst_n) begin
    if (!arst_n) begin
      shift_q     <= '0;
      prev_data_q <= '0;
      prev_k_q    <= '0;
      align_bus   <= '0;
    end else begin
      shift_q <= shift_d;
      for (int l = 0; l < n_lanes; l++) begin
        prev_data_q[l] <= fix_bus[l].data[1];
        prev_k_q[l]    <= fix_bus[l].charisk[1];
      end
      align_bus <= align_d;  // lock rides along with the word
    end
  end

endmodule

`default_nettype wire

/* hdl/rx_lane_monitor.sv */
`default_nettype none

module rx_lane_monitor (
  input  logic                  mgt_clk,
  input  logic                  arst_n,
  input  xaui_pkg::align_word_t align_bus,
  input  logic                  enchansync,
  output xaui_pkg::rx_word_t    rx,
  output xaui_pkg::rx_status_t  status
);

  import xaui_pkg::*;

  rx_word_t           rx_d;
  rx_status_t         status_d;
  logic [n_lanes-1:0] align_seen;  // /A/ present in this word

  // control codes the xaui code space allows
  function automatic logic is_ctrl_code(input logic [7:0] code);
    case (code)
      k28_5, k28_3, k28_0, k28_4, k27_7, k29_7, k30_7: return 1'b1;
      default:                                          return 1'b0;
    endcase
  endfunction

  always_comb begin
    rx_d       = '0;
    status_d   = '0;
    align_seen = '0;

    // pack lanes into the user word
    for (int l = 0; l < n_lanes; l++) begin
      for (int j = 0; j < 2; j++) begin
        rx_d.data[2*l+j]    = align_bus.lanes[l].data[j];
        rx_d.charisk[2*l+j] = align_bus.lanes[l].charisk[j];
        if (align_bus.lanes[l].charisk[j] && (align_bus.lanes[l].data[j] == k28_3)) begin
          align_seen[l] = 1'b1;
        end
      end
    end

    // byte flags
    for (int b = 0; b < n_bytes; b++) begin
      status_d.code_comma[b] = rx_d.charisk[b] && (rx_d.data[b] == k28_5);
      status_d.codevalid[b]  = !rx_d.charisk[b] || is_ctrl_code(rx_d.data[b]);
    end

    status_d.rxlock = align_bus.lock;

    // sticky while enchansync holds, drops as soon as it goes low
    for (int l = 0; l < n_lanes; l++) begin
      status_d.syncok[l] = enchansync && (status.syncok[l] || align_seen[l]);
    end
  end

  always_ff @(posedge mgt_clk or negedge arst_n) begin
    if (!arst_n) begin
      rx     <= '0;
      status <= '0;
    end else begin
      rx     <= rx_d;
      status <= status_d;
    end
  end

endmodule

`default_nettype wire

/* hdl/xaui_lane_top.sv */
`default_nettype none

module xaui_lane_top #(
  parameter logic [xaui_pkg::n_lanes-1:0] tx_polarity = 4'b1010,  // lanes 3 and 1
  parameter logic [xaui_pkg::n_lanes-1:0] rx_polarity = 4'b0101,  // lanes 2 and 0
  parameter bit                           rx_reverse  = 1'b1      // rx pairs crossed
) (
  input  logic                         mgt_clk,
  input  logic                         arst_n,
  input  xaui_pkg::tx_word_t           tx,
  input  xaui_pkg::lane_bus_t          rx_lanes,
  input  logic                         loopback,
  input  logic [xaui_pkg::n_lanes-1:0] enable_align,  // logical lane order
  input  logic                         enchansync,
  output xaui_pkg::lane_bus_t          tx_lanes,
  output xaui_pkg::rx_word_t           rx,
  output xaui_pkg::rx_status_t         status
);

  import xaui_pkg::*;

  lane_bus_t   fix_bus;    // stage 1, lanes in logical order
  align_word_t align_bus;  // stage 2, byte aligned

  xaui_lane_fixup #(
    .tx_polarity (tx_polarity),
    .rx_polarity (rx_polarity),
    .rx_reverse  (rx_reverse)
  ) i_xaui_lane_fixup (
    .mgt_clk  (mgt_clk),
    .arst_n   (arst_n),
    .tx       (tx),
    .rx_lanes (rx_lanes),
    .loopback (loopback),
    .tx_lanes (tx_lanes),
    .fix_bus  (fix_bus)
  );

  rx_comma_align i_rx_comma_align (
    .mgt_clk      (mgt_clk),
    .arst_n       (arst_n),
    .fix_bus      (fix_bus),
    .enable_align (enable_align),
    .align_bus    (align_bus)
  );

  rx_lane_monitor i_rx_lane_monitor (
    .mgt_clk    (mgt_clk),
    .arst_n     (arst_n),
    .align_bus  (align_bus),
    .enchansync (enchansync),
    .rx         (rx),
    .status     (status)
  );

endmodule

`default_nettype wire

/* bench/xaui_lane_properties.sv */
`default_nettype none

module xaui_lane_properties (
  input logic                         mgt_clk,
  input logic                         arst_n,
  input logic [xaui_pkg::n_lanes-1:0] enable_align,
  input logic [xaui_pkg::n_lanes-1:0] shift,
  input xaui_pkg::align_word_t        align_bus
);

  timeunit 1ns;
  timeprecision 100ps;

  import xaui_pkg::*;

  for (genvar l = 0; l < n_lanes; l++) begin : g_lane
    // lock register follows enable_align on the next edge
    lock_drops: assert property (@(posedge mgt_clk) disable iff (!arst_n)
      !enable_align[l] |=> !align_bus.lock[l])
      else $error("lane %0d lock still set after enable_align went low", l);

    shift_frozen: assert property (@(posedge mgt_clk) disable iff (!arst_n)
      !enable_align[l] |=> $stable(shift[l]))
      else $error("lane %0d shift flag moved while enable_align was low", l);
  end

  lock_in_reset: assert property (@(posedge mgt_clk)
    !arst_n |=> (align_bus.lock == '0))
    else $error("lock set while reset was active");

endmodule

bind rx_comma_align xaui_lane_properties i_xaui_lane_properties (
  .mgt_clk      (mgt_clk),
  .arst_n       (arst_n),
  .enable_align (enable_align),
  .shift        (shift_q),
  .align_bus    (align_bus)
);

`default_nettype wire

/* bench/xaui_lane_tb.sv */
`default_nettype none

module xaui_lane_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import xaui_pkg::*;

  localparam logic [n_lanes-1:0] tx_pol = 4'b1010;  // board inverts tx lanes 3 and 1
  localparam logic [n_lanes-1:0] rx_pol = 4'b0101;  // board inverts rx lanes 2 and 0
  localparam bit                 rx_rev = 1'b1;     // rx pairs crossed
  localparam int phase_cycles = 600;
  localparam int n_phases     = 4;
  localparam int max_cycles   = n_phases * phase_cycles + 600;  // reset plus margin

  localparam logic [7:0] listed_codes [7] = '{k28_5, k28_3, k28_0, k28_4, k27_7, k29_7, k30_7};

  logic               mgt_clk;
  logic               arst_n;
  tx_word_t           tx;
  lane_bus_t          rx_lanes;
  logic               loopback;
  logic [n_lanes-1:0] enable_align;
  logic               enchansync;
  lane_bus_t          tx_lanes;
  rx_word_t           rx;
  rx_status_t         status;

  // reference pipeline state
  lane_bus_t               m_tx_lanes;
  lane_bus_t               m_loop_q;
  lane_bus_t               m_fix;
  lane_bus_t               m_align;
  logic [n_lanes-1:0]      m_lock;
  logic [n_lanes-1:0]      m_shift;
  logic [n_lanes-1:0][8:0] m_prev;  // k flag and byte 1 of the last word
  rx_word_t                m_rx;
  rx_status_t              m_status;
  tx_word_t                tx_hist[$];  // tx as sampled on recent edges
  int                      lb_run;      // edges in a row with loopback high

  logic [31:0] rng_state = 32'h0352_4582;
  int          cycle_count = 0;
  int          lane_errors;
  int          rx_errors;
  int          status_errors;
  int          other_errors;
  int          lock_cycles;
  int          shift_cycles;
  int          sync_cycles;

  xaui_lane_top #(
    .tx_polarity (tx_pol),
    .rx_polarity (rx_pol),
    .rx_reverse  (rx_rev)
  ) i_xaui_lane_top (
    .mgt_clk      (mgt_clk),
    .arst_n       (arst_n),
    .tx           (tx),
    .rx_lanes     (rx_lanes),
    .loopback     (loopback),
    .enable_align (enable_align),
    .enchansync   (enchansync),
    .tx_lanes     (tx_lanes),
    .rx           (rx),
    .status       (status)
  );

  initial begin
    mgt_clk = 1'b0;
    forever #50 mgt_clk = ~mgt_clk;
  end

  always @(posedge mgt_clk) cycle_count <= cycle_count + 1;

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // random {k, data} byte drawn from data, listed codes or any control byte
  function automatic logic [8:0] random_byte();
    logic [31:0] r;
    int          idx;
    r = next_rand();
    idx = int'(r[31:8] % 24'd7);
    case (r[2:0])
      3'd4, 3'd5: return {1'b1, listed_codes[idx]};
      3'd6:       return {1'b1, r[15:8]};
      default:    return {1'b0, r[15:8]};
    endcase
  endfunction

  function automatic lane_word_t random_lane();
    lane_word_t w;
    logic [8:0] b;
    for (int j = 0; j < 2; j++) begin
      b = random_byte();
      w.charisk[j] = b[8];
      w.data[j]    = b[7:0];
    end
    return w;
  endfunction

  // puts code on external lane e pre-inverted where the board flips it
  function automatic lane_word_t with_code(input lane_word_t w, input int e, input int j,
                                           input logic [7:0] code);
    lane_word_t res;
    res = w;
    res.charisk[j] = 1'b1;
    res.data[j]    = rx_pol[e] ? ~code : code;
    return res;
  endfunction

  function automatic bit is_listed(input logic [7:0] code);
    for (int i = 0; i < 7; i++) begin
      if (listed_codes[i] == code) return 1'b1;
    end
    return 1'b0;
  endfunction

  function automatic lane_bus_t split_tx(input tx_word_t t);
    lane_bus_t res;
    for (int b = 0; b < n_bytes; b++) begin
      res[b/2].data[b%2]    = t.data[b];
      res[b/2].charisk[b%2] = t.charisk[b];
    end
    return res;
  endfunction

  function automatic lane_bus_t fix_board_rx(input lane_bus_t pins);
    lane_bus_t  res;
    lane_word_t w;
    for (int e = 0; e < n_lanes; e++) begin
      w = pins[e];
      if (rx_pol[e]) w.data = ~w.data;
      res[rx_rev ? n_lanes-1-e : e] = w;
    end
    return res;
  endfunction

  // advances the reference by one rising edge starting at the last stage
  task automatic model_step();
    rx_word_t           n_rx;
    rx_status_t         n_st;
    lane_word_t         w;
    lane_bus_t          logical;
    logic [n_lanes-1:0] saw_align;
    logic               c0;
    logic               c1;
    int                 lane;
    int                 pos;
    saw_align = '0;
    n_st = '0;
    for (int b = 0; b < n_bytes; b++) begin
      lane = b / 2;
      pos  = b % 2;
      n_rx.data[b]       = m_align[lane].data[pos];
      n_rx.charisk[b]    = m_align[lane].charisk[pos];
      n_st.code_comma[b] = n_rx.charisk[b] && (n_rx.data[b] == k28_5);
      n_st.codevalid[b]  = !n_rx.charisk[b] || is_listed(n_rx.data[b]);
      if (n_rx.charisk[b] && (n_rx.data[b] == k28_3)) saw_align[lane] = 1'b1;
    end
    n_st.rxlock = m_lock;
    for (int i = 0; i < n_lanes; i++) begin
      n_st.syncok[i] = enchansync && (m_status.syncok[i] || saw_align[i]);
    end
    m_rx     = n_rx;
    m_status = n_st;

    for (int i = 0; i < n_lanes; i++) begin
      c0 = m_fix[i].charisk[0] && (m_fix[i].data[0] == k28_5);
      c1 = m_fix[i].charisk[1] && (m_fix[i].data[1] == k28_5);
      if (enable_align[i] && c0) begin
        m_shift[i] = 1'b0;
      end else if (enable_align[i] && c1) begin
        m_shift[i] = 1'b1;
      end
      w = m_fix[i];
      if (m_shift[i]) begin
        w.data    = {m_fix[i].data[0], m_prev[i][7:0]};
        w.charisk = {m_fix[i].charisk[0], m_prev[i][8]};
      end
      m_lock[i]  = enable_align[i] && (m_lock[i] || c0 || c1);
      m_prev[i]  = {m_fix[i].charisk[1], m_fix[i].data[1]};
      m_align[i] = w;
    end

    logical    = split_tx(tx);
    m_fix      = loopback ? m_loop_q : fix_board_rx(rx_lanes);
    m_loop_q   = logical;
    m_tx_lanes = logical;
    for (int i = 0; i < n_lanes; i++) begin
      if (tx_pol[i]) m_tx_lanes[i].data = ~logical[i].data;
    end

    if (m_lock != '0) lock_cycles++;
    if (m_shift != '0) shift_cycles++;
    if (m_status.syncok != '0) sync_cycles++;
    tx_hist.push_back(tx);
    if (tx_hist.size() > 4) void'(tx_hist.pop_front());
    lb_run = loopback ? lb_run + 1 : 0;
  endtask

  task automatic drive_inputs(input int phase);
    logic [31:0] r;
    for (int b = 0; b < n_bytes; b++) begin
      {tx.charisk[b], tx.data[b]} = random_byte();
    end
    for (int e = 0; e < n_lanes; e++) begin
      rx_lanes[e] = random_lane();
      r = next_rand();
      if (phase == 3 && r[2:0] == 3'd0) rx_lanes[e] = with_code(rx_lanes[e], e, int'(r[3]), k28_5);
      if (phase == 4 && r[2:0] == 3'd0) rx_lanes[e] = with_code(rx_lanes[e], e, int'(r[3]), k28_3);
      if (phase < 3) begin
        enable_align[e] = 1'b0;
      end else if (r[7:4] == 4'd0) begin
        enable_align[e] = ~enable_align[e];  // logical lane e
      end
    end
    loopback = (phase == 2);
    r = next_rand();
    if (phase < 4) begin
      enchansync = 1'b0;
    end else if (r[3:0] == 4'd0) begin
      enchansync = ~enchansync;
    end
  endtask

  task automatic check_lanes(input lane_bus_t got, input lane_bus_t exp, input string what);
    if (got !== exp) begin
      lane_errors++;
      $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_rx(input rx_word_t got, input rx_word_t exp, input string what);
    if (got !== exp) begin
      rx_errors++;
      $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_status(input rx_status_t got, input rx_status_t exp, input string what);
    if (got !== exp) begin
      status_errors++;
      $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_outputs(input int phase);
    rx_word_t looped;
    check_lanes(tx_lanes, m_tx_lanes, "tx_lanes");
    check_rx(rx, m_rx, "rx");
    check_status(status, m_status, "status");
    // oldest entry went in 3 edges ago with loopback held since then
    if (phase == 2 && lb_run >= 4 && tx_hist.size() == 4) begin
      looped = rx_word_t'(tx_hist[0]);
      check_rx(rx, looped, "loopback rx against tx");
    end
  endtask

  task automatic run_cycle(input int phase);
    @(posedge mgt_clk);
    model_step();
    #10;
    drive_inputs(phase);
    @(negedge mgt_clk);
    compare_outputs(phase);
  endtask

  initial begin : main
    int total;
    lane_errors = 0;
    rx_errors = 0;
    status_errors = 0;
    other_errors = 0;
    lock_cycles = 0;
    shift_cycles = 0;
    sync_cycles = 0;
    lb_run = 0;
    m_tx_lanes = '0;
    m_loop_q = '0;
    m_fix = '0;
    m_align = '0;
    m_lock = '0;
    m_shift = '0;
    m_prev = '0;
    m_rx = '0;
    m_status = '0;
    arst_n = 1'b0;
    tx = '0;
    rx_lanes = '0;
    loopback = 1'b0;
    enable_align = '0;
    enchansync = 1'b0;

    @(posedge mgt_clk);  // first reset edge
    @(negedge mgt_clk);
    check_lanes(tx_lanes, '0, "tx_lanes in reset");
    check_rx(rx, '0, "rx in reset");
    check_status(status, '0, "status in reset");
    @(posedge mgt_clk);  // second reset edge
    #10;
    arst_n = 1'b1;
    drive_inputs(1);

    for (int p = 1; p <= n_phases; p++) begin
      repeat (phase_cycles) run_cycle(p);
    end

    if (lock_cycles == 0 || shift_cycles == 0 || sync_cycles == 0) begin
      other_errors++;
      $display("stimulus never reached lock, shift or syncok (%0d, %0d, %0d cycles)",
               lock_cycles, shift_cycles, sync_cycles);
    end
    total = lane_errors + rx_errors + status_errors + other_errors;
    $display("errors: tx_lanes %0d, rx %0d, status %0d, other %0d",
             lane_errors, rx_errors, status_errors, other_errors);
    if (total == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    wait (cycle_count >= max_cycles);
    $display("timeout: the run did not finish within %0d cycles", max_cycles);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* xaui_lane.f */
hdl/xaui_pkg.sv
hdl/xaui_lane_fixup.sv
hdl/rx_comma_align.sv
hdl/rx_lane_monitor.sv
hdl/xaui_lane_top.sv
bench/xaui_lane_properties.sv
bench/xaui_lane_tb.sv

/* Makefile */
# Verilator build for the XAUI lane front end

VERILATOR ?= verilator
TOP       ?= xaui_lane_tb
FILELIST  ?= xaui_lane.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= STATUS: PASS

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the simulation output holds the pass message
run: compile
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
